/* src/cpu_pkg.sv */
package cpu_pkg;

	typedef logic [15:0] word_t;
	typedef logic [1:0] reg_addr_t;

	typedef enum logic [3:0] {
		OP_BNE   = 4'd0,
		OP_BEQ   = 4'd1,
		OP_ADI   = 4'd4,
		OP_LHI   = 4'd6,
		OP_LWD   = 4'd7,
		OP_SWD   = 4'd8,
		OP_JMP   = 4'd9,
		OP_RTYPE = 4'd15
	} opcode_t;

	typedef enum logic [5:0] {
		FN_ADD = 6'd0,
		FN_SUB = 6'd1,
		FN_AND = 6'd2,
		FN_ORR = 6'd3,
		FN_WWD = 6'd28,
		FN_HLT = 6'd29
	} func_t;

	// one instruction word, three ways to read it
	typedef union packed {
		struct packed {
			opcode_t opcode;
			reg_addr_t rs;
			reg_addr_t rt;
			reg_addr_t rd;
			func_t func;
		} r_fmt;
		struct packed {
			opcode_t opcode;
			reg_addr_t rs;
			reg_addr_t rt;
			logic [7:0] imm;
		} i_fmt;
		struct packed {
			opcode_t opcode;
			logic [11:0] target;
		} j_fmt;
	} inst_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_LHI, // passes operand b, already shifted to the high byte
		ALU_EQ
	} alu_op_t;

	typedef struct packed {
		logic valid;
		logic reg_write;
		logic mem_read;
		logic mem_write;
		logic mem_to_reg;
		logic alu_src;
		logic is_branch;
		logic branch_eq; // BEQ when set, BNE otherwise
		logic is_jump;
		logic is_wwd;
		logic is_hlt;
		alu_op_t alu_op;
	} ctrl_t;

	typedef struct packed {
		ctrl_t ctrl;
		word_t pc;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t rd;
		word_t reg_data1;
		word_t reg_data2;
		word_t imm;
	} id_ex_t;

	typedef struct packed {
		ctrl_t ctrl;
		reg_addr_t rd;
		word_t alu_result;
		word_t store_data; // rt for SWD, rs for WWD
	} ex_mem_t;

	typedef struct packed {
		logic reg_write;
		reg_addr_t rd;
		word_t data;
	} wb_t;

	typedef struct packed {
		logic taken;
		word_t target;
	} redirect_t;

	typedef struct packed {
		logic read;
		logic write;
		word_t addr;
		word_t wdata;
	} dmem_req_t;

endpackage

/* src/fetch_stage.sv */
module fetch_stage import cpu_pkg::*; #(
	parameter word_t RESET_PC = '0
) (
	input logic clk,
	input logic arst_n,
	input logic stall,
	input redirect_t redirect,
	output word_t imem_addr,
	input word_t imem_data,
	output word_t if_pc,
	output inst_t if_inst,
	output logic if_valid
);

	word_t pc;

	assign imem_addr = pc;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= RESET_PC;
		end else if (redirect.taken) begin // redirect wins over stall
			pc <= redirect.target;
		end else if (!stall) begin
			pc <= pc + 16'd1;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			if_valid <= 1'b0;
			if_pc <= '0;
			if_inst <= '0;
		end else if (redirect.taken) begin
			if_valid <= 1'b0;
		end else if (!stall) begin
			if_valid <= 1'b1;
			if_pc <= pc;
			if_inst <= imem_data;
		end
	end

	pc_known: assert property (@(posedge clk) disable iff (!arst_n) !$isunknown(pc));

endmodule

/* src/register_file.sv */
module register_file import cpu_pkg::*; (
	input logic clk,
	input logic arst_n,
	input reg_addr_t rd_addr1,
	input reg_addr_t rd_addr2,
	output word_t rd_data1,
	output word_t rd_data2,
	input wb_t wb
);

	word_t regs [4];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			regs <= '{default: '0};
		end else if (wb.reg_write) begin
			regs[wb.rd] <= wb.data;
		end
	end

	// write-through so the decoding instruction sees this cycle's writeback
	assign rd_data1 = (wb.reg_write && wb.rd == rd_addr1) ? wb.data : regs[rd_addr1];
	assign rd_data2 = (wb.reg_write && wb.rd == rd_addr2) ? wb.data : regs[rd_addr2];

endmodule

/* src/decode_stage.sv */
module decode_stage import cpu_pkg::*; (
	input logic clk,
	input logic arst_n,
	input word_t if_pc,
	input inst_t if_inst,
	input logic if_valid,
	input logic flush,
	output logic stall,
	input wb_t wb,
	output id_ex_t id_ex
);

	ctrl_t ctrl;
	logic use_rs;
	logic use_rt;
	reg_addr_t dest;
	word_t imm;
	word_t reg_data1;
	word_t reg_data2;

	register_file u_regs (
		.clk(clk),
		.arst_n(arst_n),
		.rd_addr1(if_inst.i_fmt.rs),
		.rd_addr2(if_inst.i_fmt.rt),
		.rd_data1(reg_data1),
		.rd_data2(reg_data2),
		.wb(wb)
	);

	always_comb begin
		ctrl = '0;
		ctrl.valid = 1'b1;
		use_rs = 1'b1;
		use_rt = 1'b0;
		dest = if_inst.i_fmt.rt;
		imm = {{8{if_inst.i_fmt.imm[7]}}, if_inst.i_fmt.imm};
		case (if_inst.r_fmt.opcode)
		OP_RTYPE: begin
			dest = if_inst.r_fmt.rd;
			case (if_inst.r_fmt.func)
			FN_ADD, FN_SUB, FN_AND, FN_ORR: begin
				ctrl.reg_write = 1'b1;
				use_rt = 1'b1;
			end
			FN_WWD: ctrl.is_wwd = 1'b1;
			FN_HLT: begin
				ctrl.is_hlt = 1'b1;
				use_rs = 1'b0;
			end
			default: use_rs = 1'b0;
			endcase
			case (if_inst.r_fmt.func)
			FN_SUB: ctrl.alu_op = ALU_SUB;
			FN_AND: ctrl.alu_op = ALU_AND;
			FN_ORR: ctrl.alu_op = ALU_OR;
			default: ctrl.alu_op = ALU_ADD;
			endcase
		end
		OP_ADI: begin
			ctrl.reg_write = 1'b1;
			ctrl.alu_src = 1'b1;
		end
		OP_LHI: begin
			ctrl.reg_write = 1'b1;
			ctrl.alu_src = 1'b1;
			ctrl.alu_op = ALU_LHI;
			use_rs = 1'b0;
			imm = {if_inst.i_fmt.imm, 8'h00};
		end
		OP_LWD: begin
			ctrl.reg_write = 1'b1;
			ctrl.mem_read = 1'b1;
			ctrl.mem_to_reg = 1'b1;
			ctrl.alu_src = 1'b1;
		end
		OP_SWD: begin
			ctrl.mem_write = 1'b1;
			ctrl.alu_src = 1'b1;
			use_rt = 1'b1; // store data
		end
		OP_BNE, OP_BEQ: begin
			ctrl.is_branch = 1'b1;
			ctrl.branch_eq = (if_inst.r_fmt.opcode == OP_BEQ);
			ctrl.alu_op = ALU_EQ;
			use_rt = 1'b1;
		end
		OP_JMP: begin
			ctrl.is_jump = 1'b1;
			use_rs = 1'b0;
			imm = {if_pc[15:12], if_inst.j_fmt.target}; // same page
		end
		default: use_rs = 1'b0;
		endcase
	end

	// load in EX whose result the decoding instruction needs
	assign stall = if_valid && id_ex.ctrl.mem_read &&
		((use_rs && if_inst.i_fmt.rs == id_ex.rd) || (use_rt && if_inst.i_fmt.rt == id_ex.rd));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			id_ex <= '0;
		end else begin
			if (if_valid && !flush && !stall)
				id_ex.ctrl <= ctrl;
			else
				id_ex.ctrl <= '0; // bubble
			id_ex.pc <= if_pc;
			id_ex.rs <= if_inst.i_fmt.rs;
			id_ex.rt <= if_inst.i_fmt.rt;
			id_ex.rd <= dest;
			id_ex.reg_data1 <= reg_data1;
			id_ex.reg_data2 <= reg_data2;
			id_ex.imm <= imm;
		end
	end

	// the bubble behind a stall can never request another one
	single_stall: assert property (@(posedge clk) disable iff (!arst_n) stall |=> !stall);

endmodule

/* src/execute_stage.sv */
module execute_stage import cpu_pkg::*; (
	input logic clk,
	input logic arst_n,
	input id_ex_t id_ex,
	input wb_t wb,
	output ex_mem_t ex_mem,
	output redirect_t redirect,
	output dmem_req_t dmem_req
);

	word_t op_a;
	word_t op_b_reg;
	word_t op_b;
	word_t alu_result;
	logic taken;
	word_t target;
	logic stopped;
	logic halt_seen;

	// EX/MEM result first, then the writeback value
	function automatic word_t forward(reg_addr_t src, word_t reg_val, ex_mem_t mem, wb_t wbk);
		if (mem.ctrl.reg_write && mem.rd == src)
			return mem.alu_result;
		if (wbk.reg_write && wbk.rd == src)
			return wbk.data;
		return reg_val;
	endfunction

	assign op_a = forward(id_ex.rs, id_ex.reg_data1, ex_mem, wb);
	assign op_b_reg = forward(id_ex.rt, id_ex.reg_data2, ex_mem, wb);
	assign op_b = id_ex.ctrl.alu_src ? id_ex.imm : op_b_reg;

	always_comb begin
		case (id_ex.ctrl.alu_op)
		ALU_ADD: alu_result = op_a + op_b;
		ALU_SUB: alu_result = op_a - op_b;
		ALU_AND: alu_result = op_a & op_b;
		ALU_OR:  alu_result = op_a | op_b;
		ALU_LHI: alu_result = op_b;
		ALU_EQ:  alu_result = {15'd0, op_a == op_b};
		default: alu_result = '0;
		endcase
	end

	assign taken = id_ex.ctrl.is_jump ||
		(id_ex.ctrl.is_branch && (alu_result[0] == id_ex.ctrl.branch_eq));
	assign target = id_ex.ctrl.is_jump ? id_ex.imm : id_ex.pc + 16'd1 + id_ex.imm;

	// nothing issues past a halt that has reached MEM
	assign halt_seen = stopped || ex_mem.ctrl.is_hlt;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_mem <= '0;
			redirect <= '0;
			stopped <= 1'b0;
		end else begin
			stopped <= halt_seen;
			if (redirect.taken || halt_seen)
				ex_mem.ctrl <= '0; // flushed with the rest of the shadow
			else
				ex_mem.ctrl <= id_ex.ctrl;
			ex_mem.rd <= id_ex.rd;
			ex_mem.alu_result <= alu_result;
			ex_mem.store_data <= id_ex.ctrl.is_wwd ? op_a : op_b_reg;
			redirect.taken <= taken && !redirect.taken && !halt_seen;
			redirect.target <= target;
		end
	end

	assign dmem_req.read = ex_mem.ctrl.mem_read;
	assign dmem_req.write = ex_mem.ctrl.mem_write;
	assign dmem_req.addr = ex_mem.alu_result;
	assign dmem_req.wdata = ex_mem.store_data;

	mem_rw_excl: assert property (@(posedge clk) disable iff (!arst_n)
		!(dmem_req.read && dmem_req.write));

endmodule

/* src/retire_stage.sv */
module retire_stage import cpu_pkg::*; (
	input logic clk,
	input logic arst_n,
	input ex_mem_t ex_mem,
	input word_t dmem_rdata,
	output wb_t wb,
	output word_t output_port,
	output logic out_valid,
	output word_t num_inst,
	output logic halted
);

	logic retire;

	assign retire = ex_mem.ctrl.valid && !halted; // frozen once halted

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb <= '0;
			output_port <= '0;
			out_valid <= 1'b0;
			num_inst <= '0;
			halted <= 1'b0;
		end else begin
			wb.reg_write <= retire && ex_mem.ctrl.reg_write;
			wb.rd <= ex_mem.rd;
			wb.data <= ex_mem.ctrl.mem_to_reg ? dmem_rdata : ex_mem.alu_result;
			out_valid <= retire && ex_mem.ctrl.is_wwd;
			if (retire && ex_mem.ctrl.is_wwd)
				output_port <= ex_mem.store_data;
			if (retire)
				num_inst <= num_inst + 16'd1;
			if (retire && ex_mem.ctrl.is_hlt)
				halted <= 1'b1; // sticky until reset
		end
	end

	quiet_after_halt: assert property (@(posedge clk) disable iff (!arst_n)
		halted |=> halted && !out_valid);

endmodule

/* src/cpu.sv */
module cpu import cpu_pkg::*; #(
	parameter word_t RESET_PC = '0
) (
	input logic clk,
	input logic arst_n,
	output word_t imem_addr,
	input word_t imem_data,
	output dmem_req_t dmem_req,
	input word_t dmem_rdata,
	output word_t output_port,
	output logic out_valid,
	output word_t num_inst,
	output logic halted
);

	logic stall;
	redirect_t redirect;
	word_t if_pc;
	inst_t if_inst;
	logic if_valid;
	id_ex_t id_ex;
	ex_mem_t ex_mem;
	wb_t wb;

	fetch_stage #(
		.RESET_PC(RESET_PC)
	) u_fetch (
		.clk(clk),
		.arst_n(arst_n),
		.stall(stall),
		.redirect(redirect),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.if_pc(if_pc),
		.if_inst(if_inst),
		.if_valid(if_valid)
	);

	decode_stage u_decode (
		.clk(clk),
		.arst_n(arst_n),
		.if_pc(if_pc),
		.if_inst(if_inst),
		.if_valid(if_valid),
		.flush(redirect.taken), // taken branch kills ID as well
		.stall(stall),
		.wb(wb),
		.id_ex(id_ex)
	);

	execute_stage u_execute (
		.clk(clk),
		.arst_n(arst_n),
		.id_ex(id_ex),
		.wb(wb),
		.ex_mem(ex_mem),
		.redirect(redirect),
		.dmem_req(dmem_req)
	);

	retire_stage u_retire (
		.clk(clk),
		.arst_n(arst_n),
		.ex_mem(ex_mem),
		.dmem_rdata(dmem_rdata),
		.wb(wb),
		.output_port(output_port),
		.out_valid(out_valid),
		.num_inst(num_inst),
		.halted(halted)
	);

endmodule

/* bench/tb_cpu.sv */
module tb_cpu import cpu_pkg::*; ();

	localparam word_t START_PC = 16'h0000;
	localparam int NUM_RANDOM = 50;
	localparam word_t HLT_WORD = {OP_RTYPE, 6'd0, FN_HLT};

	logic clk;
	logic arst_n;
	word_t imem_addr;
	word_t imem_data;
	dmem_req_t dmem_req;
	word_t dmem_rdata;
	word_t output_port;
	logic out_valid;
	word_t num_inst;
	logic halted;

	word_t rom [256];
	word_t ram [256];
	word_t ref_mem [256]; // image the interpreter expects at halt
	word_t exp_out [$];
	word_t code [$];
	int cycle_count = 0;
	int cycle_limit = 0;

	cpu #(
		.RESET_PC(START_PC)
	) UUT (
		.clk(clk),
		.arst_n(arst_n),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.dmem_req(dmem_req),
		.dmem_rdata(dmem_rdata),
		.output_port(output_port),
		.out_valid(out_valid),
		.num_inst(num_inst),
		.halted(halted)
	);

	// both memories answer in the same cycle
	assign imem_data = rom[imem_addr[7:0]];
	assign dmem_rdata = ram[dmem_req.addr[7:0]];

	always @(posedge clk) begin
		if (dmem_req.write)
			ram[dmem_req.addr[7:0]] <= dmem_req.wdata;
	end

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic stop_on_error(string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic check_word(string name, word_t actual, word_t expected);
		if (actual !== expected)
			stop_on_error($sformatf("[ERROR] t=%0t %s: got %h, expected %h",
				$time, name, actual, expected));
	endtask

	task automatic check_flag(string name, logic actual, logic expected);
		if (actual !== expected)
			stop_on_error($sformatf("[ERROR] t=%0t %s: got %b, expected %b",
				$time, name, actual, expected));
	endtask

	function automatic word_t rtype(int fn, int rs, int rt, int rd);
		return {OP_RTYPE, rs[1:0], rt[1:0], rd[1:0], fn[5:0]};
	endfunction

	function automatic word_t itype(int op, int rs, int rt, int imm);
		return {op[3:0], rs[1:0], rt[1:0], imm[7:0]};
	endfunction

	function automatic word_t jump_to(int target);
		return {OP_JMP, target[11:0]};
	endfunction

	// plain instruction-by-instruction interpreter
	function automatic int run_reference();
		word_t regs [4];
		word_t pc;
		word_t pc_next;
		word_t w;
		word_t a;
		word_t b;
		word_t simm;
		word_t addr;
		int count;
		logic done;
		regs = '{default: '0};
		pc = START_PC;
		count = 0;
		done = 1'b0;
		exp_out.delete();
		while (!done && count < 4000) begin
			w = rom[pc[7:0]];
			a = regs[w[11:10]];
			b = regs[w[9:8]];
			simm = {{8{w[7]}}, w[7:0]};
			addr = a + simm;
			pc_next = pc + 16'd1;
			count++;
			case (w[15:12])
			OP_RTYPE: begin
				case (w[5:0])
				FN_ADD: regs[w[7:6]] = a + b;
				FN_SUB: regs[w[7:6]] = a - b;
				FN_AND: regs[w[7:6]] = a & b;
				FN_ORR: regs[w[7:6]] = a | b;
				FN_WWD: exp_out.push_back(a);
				FN_HLT: done = 1'b1;
				default: ;
				endcase
			end
			OP_ADI: regs[w[9:8]] = addr;
			OP_LHI: regs[w[9:8]] = {w[7:0], 8'h00};
			OP_LWD: regs[w[9:8]] = ref_mem[addr[7:0]];
			OP_SWD: ref_mem[addr[7:0]] = b;
			OP_BNE: if (a != b) pc_next = pc_next + simm;
			OP_BEQ: if (a == b) pc_next = pc_next + simm;
			OP_JMP: pc_next = {pc[15:12], w[11:0]};
			default: ;
			endcase
			pc = pc_next;
		end
		return count;
	endfunction

	task automatic build_directed(int which);
		case (which)
		0: code = '{HLT_WORD};
		1: code = '{ // dependent ALU chains
			itype(OP_LHI, 0, 1, 8'h12), itype(OP_ADI, 1, 1, 8'h34),
			itype(OP_ADI, 0, 2, -3), rtype(FN_ADD, 1, 2, 3),
			rtype(FN_SUB, 3, 1, 0), rtype(FN_WWD, 0, 0, 0),
			rtype(FN_AND, 3, 0, 2), rtype(FN_ORR, 2, 1, 1),
			rtype(FN_WWD, 1, 0, 0), rtype(FN_WWD, 2, 0, 0),
			itype(OP_ADI, 0, 2, 5), itype(OP_LHI, 0, 0, 8'ha5),
			itype(OP_ADI, 3, 3, 8'h7f), rtype(FN_WWD, 2, 0, 0), // r2 at distance 3
			rtype(FN_ORR, 3, 0, 1), rtype(FN_WWD, 1, 0, 0), HLT_WORD};
		2: code = '{ // load followed by a use
			itype(OP_ADI, 0, 1, 8'h10), itype(OP_LWD, 1, 2, 0),
			rtype(FN_ADD, 2, 2, 3), rtype(FN_WWD, 3, 0, 0),
			itype(OP_LWD, 1, 0, 1), rtype(FN_WWD, 0, 0, 0),
			itype(OP_LWD, 1, 3, 2), itype(OP_BEQ, 3, 3, 0),
			rtype(FN_WWD, 3, 0, 0), itype(OP_LWD, 1, 1, 3),
			itype(OP_LWD, 1, 1, 4), rtype(FN_WWD, 1, 0, 0), HLT_WORD};
		3: code = '{ // branches, jump and a short loop
			itype(OP_ADI, 0, 1, 5), itype(OP_ADI, 0, 2, 5),
			itype(OP_BEQ, 1, 2, 3), rtype(FN_WWD, 1, 0, 0),
			itype(OP_ADI, 1, 1, 1), HLT_WORD,
			itype(OP_BNE, 1, 2, 2), rtype(FN_WWD, 2, 0, 0),
			itype(OP_ADI, 2, 2, 1), itype(OP_BNE, 1, 2, 2),
			itype(OP_ADI, 0, 3, 8'h55), rtype(FN_WWD, 3, 0, 0),
			itype(OP_BEQ, 1, 2, 2), jump_to(17),
			itype(OP_ADI, 1, 1, 9), rtype(FN_WWD, 1, 0, 0),
			HLT_WORD, rtype(FN_WWD, 2, 0, 0),
			itype(OP_ADI, 0, 3, 3), itype(OP_ADI, 3, 3, -1),
			rtype(FN_WWD, 3, 0, 0), itype(OP_BNE, 3, 0, -3), HLT_WORD};
		default: code = '{ // stores and loads at the same address
			itype(OP_ADI, 0, 1, 8'h20), itype(OP_LHI, 0, 2, 8'hbe),
			itype(OP_ADI, 2, 2, 8'h7f), itype(OP_SWD, 1, 2, 0),
			itype(OP_LWD, 1, 3, 0), rtype(FN_WWD, 3, 0, 0),
			itype(OP_ADI, 3, 0, 1), itype(OP_SWD, 1, 0, -1),
			itype(OP_SWD, 1, 0, 2), itype(OP_LWD, 1, 2, -1),
			rtype(FN_ADD, 2, 3, 2), rtype(FN_WWD, 2, 0, 0),
			itype(OP_SWD, 0, 2, 8'h70), HLT_WORD};
		endcase
	endtask

	task automatic build_random();
		int len;
		int off;
		logic [15:0] rnd;
		len = 20 + $urandom % 21;
		code.delete();
		for (int i = 0; i < len; i++) begin
			rnd = $urandom;
			off = rnd[9:8];
			if (i + 1 + off > len)
				off = len - i - 1; // never past the final HLT
			case ($urandom % 10)
			0, 1: code.push_back(rtype(rnd[7:6], rnd[1:0], rnd[3:2], rnd[5:4]));
			2, 3: code.push_back(itype(OP_ADI, rnd[1:0], rnd[3:2], rnd[15:8]));
			4: code.push_back(itype(OP_LHI, 0, rnd[3:2], rnd[15:8]));
			5: code.push_back(itype(OP_LWD, rnd[1:0], rnd[3:2], rnd[15:8]));
			6: code.push_back(itype(OP_SWD, rnd[1:0], rnd[3:2], rnd[15:8]));
			7, 8: code.push_back(rtype(FN_WWD, rnd[1:0], 0, 0));
			default: begin
				if (rnd[4])
					code.push_back(itype(OP_BEQ, rnd[1:0], rnd[3:2], off));
				else
					code.push_back(itype(OP_BNE, rnd[1:0], rnd[3:2], off));
			end
			endcase
		end
		code.push_back(HLT_WORD);
	endtask

	task automatic prepare_memories(int prog);
		for (int i = 0; i < 256; i++) begin
			rom[i] = HLT_WORD;
			ram[i] = word_t'(i * 16'h9e37) ^ word_t'(prog * 16'h0101) ^ 16'h5a3c;
			ref_mem[i] = ram[i];
		end
		foreach (code[i])
			rom[int'(START_PC) + i] = code[i];
	endtask

	// each WWD pulse is matched in order against the interpreter output
	always @(negedge clk) begin
		if (arst_n && out_valid) begin
			if (exp_out.size() == 0)
				stop_on_error("output_port pulsed with no WWD value left to expect");
			else
				check_word("output_port", output_port, exp_out.pop_front());
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > cycle_limit)
			stop_on_error($sformatf("timeout: run did not finish within %0d cycles",
				cycle_limit));
	end

	initial begin
		int count;
		void'($urandom(32'h123a_57c5));
		arst_n = 1'b0;
		for (int prog = 0; prog < 5 + NUM_RANDOM; prog++) begin
			if (prog < 5)
				build_directed(prog);
			else
				build_random();
			prepare_memories(prog);
			count = run_reference();
			cycle_limit += 4 * count + 40;
			@(posedge clk);
			arst_n <= 1'b0;
			repeat (15) @(posedge clk);
			@(negedge clk);
			check_flag("out_valid", out_valid, 1'b0);
			check_flag("halted", halted, 1'b0);
			check_word("num_inst", num_inst, 16'd0);
			check_word("imem_addr", imem_addr, START_PC);
			check_flag("dmem_req.read", dmem_req.read, 1'b0);
			check_flag("dmem_req.write", dmem_req.write, 1'b0);
			@(posedge clk);
			arst_n <= 1'b1;
			while (!halted)
				@(negedge clk);
			check_word("num_inst", num_inst, word_t'(count));
			repeat (10) begin
				@(negedge clk);
				check_flag("out_valid", out_valid, 1'b0);
			end
			if (exp_out.size() != 0)
				stop_on_error($sformatf("program %0d halted with %0d WWD values never output",
					prog, exp_out.size()));
			for (int i = 0; i < 256; i++)
				check_word($sformatf("ram[%0d]", i), ram[i], ref_mem[i]);
		end
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

/* sources.f */
src/cpu_pkg.sv
src/fetch_stage.sv
src/register_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/retire_stage.sv
src/cpu.sv
bench/tb_cpu.sv
